//--- link_mon_pkg.sv
// Shared types for the NCU-MCU nibble link monitor.
// Holds the beat and packet widths, both command tables, the link signal
// bundle and the report record that leaves the monitor.
package link_mon_pkg;

    localparam int NIBBLE_W = 4;
    localparam int PKT_W = 128;

    typedef logic [NIBBLE_W-1:0] nibble_t;
    typedef logic [PKT_W-1:0] packet_t;

    // DIR_DOWN is NCU to MCU, DIR_UP is MCU to NCU
    typedef enum logic
    {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } dir_e;

    typedef enum logic [NIBBLE_W-1:0]
    {
        READ_REQ  = 4'b0100,
        WRITE_REQ = 4'b0101,
        IFILL_REQ = 4'b0110
    } dn_cmd_e;

    typedef enum logic [NIBBLE_W-1:0]
    {
        READ_NACK  = 4'b0000,
        READ_ACK   = 4'b0001,
        IFILL_ACK  = 4'b0011,
        IFILL_NACK = 4'b0111,
        INT        = 4'b1000,
        INT_VEC    = 4'b1100
    } up_cmd_e;

    // The first nibble of a packet, read with the table of its direction
    typedef union packed
    {
        dn_cmd_e dn;
        up_cmd_e up;
    } cmd_u;

    // Observed signals of one link direction
    typedef struct packed
    {
        logic    vld;
        nibble_t data;
        logic    stall;
    } link_t;

    typedef logic [7:0] stall_cnt_t;
    typedef logic [7:0] abort_cnt_t;

    typedef struct packed
    {
        dir_e       dir;
        cmd_u       cmd;
        logic       cmd_known;
        stall_cnt_t stall_cnt;
        packet_t    packet;
    } report_t;

endpackage

//--- nibble_assembler.sv
// Packet assembly for one direction of the nibble link.
// Accepted beats (valid high, stall low) fill the packet LSB nibble first.
// When valid falls the packet is flagged done after exactly NIBBLES beats,
// otherwise it is flagged as an abort.
`timescale 1ns/1ns

module nibble_assembler #(
    parameter int NIBBLES = 32
) (
    input  logic                     iol2clk,
    input  logic                     rst_n,
    input  link_mon_pkg::link_t      link,
    output logic                     pkt_done,
    output logic                     pkt_abort,
    output link_mon_pkg::packet_t    pkt,
    output link_mon_pkg::stall_cnt_t stall_cnt
);

    localparam int CNT_W = $clog2(NIBBLES + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(NIBBLES);

    logic [CNT_W-1:0]         beat_cnt;
    logic                     vld_q;
    logic                     stall_q;
    link_mon_pkg::stall_cnt_t stall_acc;
    logic                     accept;
    logic                     pkt_end;
    logic                     stall_rise;

    // Beats past NIBBLES are dropped but keep the packet open
    assign accept = link.vld && !link.stall && (beat_cnt < FULL_CNT);
    assign pkt_end = vld_q && !link.vld;
    // Only stalls that start while valid is high belong to a packet
    assign stall_rise = link.vld && link.stall && !stall_q;

    always_ff @(posedge iol2clk)
    begin
        if (!rst_n)
        begin
            beat_cnt  <= '0;
            vld_q     <= 1'b0;
            stall_q   <= 1'b0;
            stall_acc <= '0;
            pkt_done  <= 1'b0;
            pkt_abort <= 1'b0;
        end
        else
        begin
            vld_q     <= link.vld;
            stall_q   <= link.stall;
            pkt_done  <= pkt_end && (beat_cnt == FULL_CNT);
            pkt_abort <= pkt_end && (beat_cnt != FULL_CNT);
            if (!link.vld)
            begin
                beat_cnt  <= '0;
                stall_acc <= '0;
            end
            else
            begin
                if (accept)
                    beat_cnt <= beat_cnt + 1'b1;
                if (stall_rise && (stall_acc != '1))
                    stall_acc <= stall_acc + 1'b1;
            end
        end
    end

    // Packet and stall count stay put through the done cycle
    always_ff @(posedge iol2clk)
    begin
        if (accept)
        begin
            if (beat_cnt == '0)
                pkt <= link_mon_pkg::packet_t'(link.data);
            else
                pkt[beat_cnt * link_mon_pkg::NIBBLE_W +: link_mon_pkg::NIBBLE_W] <= link.data;
        end
        if (pkt_end)
            stall_cnt <= stall_acc;
    end

    assert property (@(posedge iol2clk) disable iff (!rst_n) !(pkt_done && pkt_abort));

    assert property (@(posedge iol2clk) disable iff (!rst_n) beat_cnt <= FULL_CNT);

endmodule

//--- report_builder.sv
// Report entry for one direction.
// Decodes the command nibble of a finished packet with the table of DIR and
// holds the result until the controller takes it. A packet that arrives
// while the entry is still held is dropped and flagged.
`timescale 1ns/1ns

module report_builder #(
    parameter link_mon_pkg::dir_e DIR = link_mon_pkg::DIR_DOWN
) (
    input  logic                     iol2clk,
    input  logic                     rst_n,
    input  logic                     pkt_done,
    input  link_mon_pkg::packet_t    pkt,
    input  link_mon_pkg::stall_cnt_t stall_cnt,
    input  logic                     take,
    output link_mon_pkg::report_t    entry,
    output logic                     full,
    output logic                     overflow_pulse
);

    link_mon_pkg::cmd_u cmd;
    logic               cmd_known;
    logic               load;

    assign cmd = pkt[link_mon_pkg::NIBBLE_W-1:0];

    always_comb
    begin
        cmd_known = 1'b0;
        if (DIR == link_mon_pkg::DIR_DOWN)
        begin
            case (cmd.dn)
                link_mon_pkg::READ_REQ,
                link_mon_pkg::WRITE_REQ,
                link_mon_pkg::IFILL_REQ: cmd_known = 1'b1;
                default:                 cmd_known = 1'b0;
            endcase
        end
        else
        begin
            case (cmd.up)
                link_mon_pkg::READ_NACK,
                link_mon_pkg::READ_ACK,
                link_mon_pkg::IFILL_ACK,
                link_mon_pkg::IFILL_NACK,
                link_mon_pkg::INT,
                link_mon_pkg::INT_VEC:   cmd_known = 1'b1;
                default:                 cmd_known = 1'b0;
            endcase
        end
    end

    // A take in the same cycle frees the slot for the new packet
    assign load = pkt_done && (!full || take);
    assign overflow_pulse = pkt_done && full && !take;

    always_ff @(posedge iol2clk)
    begin
        if (!rst_n)
            full <= 1'b0;
        else if (load)
            full <= 1'b1;
        else if (take)
            full <= 1'b0;
    end

    always_ff @(posedge iol2clk)
    begin
        if (load)
        begin
            entry.dir       <= DIR;
            entry.cmd       <= cmd;
            entry.cmd_known <= cmd_known;
            entry.stall_cnt <= stall_cnt;
            entry.packet    <= pkt;
        end
    end

    assert property (@(posedge iol2clk) disable iff (!rst_n) take |-> full);

endmodule

//--- report_ctrl.sv
// Report output controller.
// Picks a held entry, downstream first, and hands it out over a four-phase
// req/ack handshake. Also keeps the sticky overflow flag and the abort
// counters of both directions.
`timescale 1ns/1ns

module report_ctrl (
    input  logic                     iol2clk,
    input  logic                     rst_n,
    input  link_mon_pkg::report_t    dn_entry,
    input  logic                     dn_full,
    input  link_mon_pkg::report_t    up_entry,
    input  logic                     up_full,
    input  logic                     dn_overflow_pulse,
    input  logic                     up_overflow_pulse,
    input  logic                     dn_abort,
    input  logic                     up_abort,
    input  logic                     rpt_ack,
    output logic                     dn_take,
    output logic                     up_take,
    output logic                     rpt_req,
    output link_mon_pkg::report_t    rpt,
    output logic                     overflow,
    output link_mon_pkg::abort_cnt_t dn_abort_cnt,
    output link_mon_pkg::abort_cnt_t up_abort_cnt
);

    typedef enum logic [1:0]
    {
        IDLE,
        REQ,
        WAIT_ACK_LOW
    } state_e;

    state_e state;
    logic   launch;

    function automatic link_mon_pkg::abort_cnt_t sat_inc(input link_mon_pkg::abort_cnt_t v);
        return (v == '1) ? v : v + 1'b1;
    endfunction

    // Ack must be low again before a new request goes out
    assign launch = (state == IDLE) && !rpt_ack && (dn_full || up_full);

    always_ff @(posedge iol2clk)
    begin
        if (!rst_n)
        begin
            state   <= IDLE;
            rpt_req <= 1'b0;
            dn_take <= 1'b0;
            up_take <= 1'b0;
        end
        else
        begin
            dn_take <= 1'b0;
            up_take <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (launch)
                    begin
                        rpt_req <= 1'b1;
                        state   <= REQ;
                    end
                end
                REQ:
                begin
                    if (rpt_ack)
                    begin
                        rpt_req <= 1'b0;
                        dn_take <= (rpt.dir == link_mon_pkg::DIR_DOWN);
                        up_take <= (rpt.dir == link_mon_pkg::DIR_UP);
                        state   <= WAIT_ACK_LOW;
                    end
                end
                WAIT_ACK_LOW:
                begin
                    if (!rpt_ack)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // The record stays latched from req rise until the next launch
    always_ff @(posedge iol2clk)
    begin
        if (launch)
            rpt <= dn_full ? dn_entry : up_entry;
    end

    always_ff @(posedge iol2clk)
    begin
        if (!rst_n)
        begin
            overflow     <= 1'b0;
            dn_abort_cnt <= '0;
            up_abort_cnt <= '0;
        end
        else
        begin
            if (dn_overflow_pulse || up_overflow_pulse)
                overflow <= 1'b1;
            if (dn_abort)
                dn_abort_cnt <= sat_inc(dn_abort_cnt);
            if (up_abort)
                up_abort_cnt <= sat_inc(up_abort_cnt);
        end
    end

    assert property (@(posedge iol2clk) disable iff (!rst_n)
        rpt_req && $past(rpt_req) |-> $stable(rpt));

endmodule

//--- link_monitor_top.sv
// Top level of the NCU-MCU nibble link monitor.
// One assembler and one report builder per direction feed a shared
// controller that hands out report records over req/ack.
`timescale 1ns/1ns

module link_monitor_top #(
    parameter int NIBBLES = 32
) (
    input  logic                     iol2clk,
    input  logic                     rst_n,
    input  link_mon_pkg::link_t      dn_link,
    input  link_mon_pkg::link_t      up_link,
    input  logic                     rpt_ack,
    output logic                     rpt_req,
    output link_mon_pkg::report_t    rpt,
    output logic                     overflow,
    output link_mon_pkg::abort_cnt_t dn_abort_cnt,
    output link_mon_pkg::abort_cnt_t up_abort_cnt
);

    logic                     dn_pkt_done;
    logic                     dn_pkt_abort;
    link_mon_pkg::packet_t    dn_pkt;
    link_mon_pkg::stall_cnt_t dn_stall_cnt;
    link_mon_pkg::report_t    dn_entry;
    logic                     dn_full;
    logic                     dn_overflow_pulse;
    logic                     dn_take;

    logic                     up_pkt_done;
    logic                     up_pkt_abort;
    link_mon_pkg::packet_t    up_pkt;
    link_mon_pkg::stall_cnt_t up_stall_cnt;
    link_mon_pkg::report_t    up_entry;
    logic                     up_full;
    logic                     up_overflow_pulse;
    logic                     up_take;

    nibble_assembler #(.NIBBLES(NIBBLES)) u_dn_asm (
        .iol2clk(iol2clk), .rst_n(rst_n), .link(dn_link),
        .pkt_done(dn_pkt_done), .pkt_abort(dn_pkt_abort),
        .pkt(dn_pkt), .stall_cnt(dn_stall_cnt)
    );

    nibble_assembler #(.NIBBLES(NIBBLES)) u_up_asm (
        .iol2clk(iol2clk), .rst_n(rst_n), .link(up_link),
        .pkt_done(up_pkt_done), .pkt_abort(up_pkt_abort),
        .pkt(up_pkt), .stall_cnt(up_stall_cnt)
    );

    report_builder #(.DIR(link_mon_pkg::DIR_DOWN)) u_dn_bld (
        .iol2clk(iol2clk), .rst_n(rst_n), .pkt_done(dn_pkt_done), .pkt(dn_pkt),
        .stall_cnt(dn_stall_cnt), .take(dn_take), .entry(dn_entry),
        .full(dn_full), .overflow_pulse(dn_overflow_pulse)
    );

    report_builder #(.DIR(link_mon_pkg::DIR_UP)) u_up_bld (
        .iol2clk(iol2clk), .rst_n(rst_n), .pkt_done(up_pkt_done), .pkt(up_pkt),
        .stall_cnt(up_stall_cnt), .take(up_take), .entry(up_entry),
        .full(up_full), .overflow_pulse(up_overflow_pulse)
    );

    report_ctrl u_ctrl (
        .iol2clk(iol2clk), .rst_n(rst_n),
        .dn_entry(dn_entry), .dn_full(dn_full),
        .up_entry(up_entry), .up_full(up_full),
        .dn_overflow_pulse(dn_overflow_pulse), .up_overflow_pulse(up_overflow_pulse),
        .dn_abort(dn_pkt_abort), .up_abort(up_pkt_abort),
        .rpt_ack(rpt_ack), .dn_take(dn_take), .up_take(up_take),
        .rpt_req(rpt_req), .rpt(rpt), .overflow(overflow),
        .dn_abort_cnt(dn_abort_cnt), .up_abort_cnt(up_abort_cnt)
    );

endmodule

//--- tb_link_monitor.sv
// Testbench for the nibble link monitor.
// Reads one test per line from link_monitor_input.txt, sends the packets on
// the downstream and upstream links and checks each report record, the
// abort counters and the overflow flag against values built from the tests.
`timescale 1ns/1ns

module tb_link_monitor;

    localparam int NIBBLES = 32;
    localparam int SLOTS = link_mon_pkg::PKT_W / link_mon_pkg::NIBBLE_W;
    localparam int MAX_TESTS = 64;

    logic                     iol2clk;
    logic                     rst_n;
    link_mon_pkg::link_t      dn_link;
    link_mon_pkg::link_t      up_link;
    logic                     rpt_ack;
    logic                     rpt_req;
    link_mon_pkg::report_t    rpt;
    logic                     overflow;
    link_mon_pkg::abort_cnt_t dn_abort_cnt;
    link_mon_pkg::abort_cnt_t up_abort_cnt;

    int                       n_tests;
    int                       t_dir [MAX_TESTS];
    int                       t_mode [MAX_TESTS];
    int                       t_beats [MAX_TESTS];
    int                       t_stall [MAX_TESTS];
    int                       t_delay [MAX_TESTS];
    link_mon_pkg::packet_t    t_pkt [MAX_TESTS];

    link_mon_pkg::report_t    exp_dn [$];
    link_mon_pkg::report_t    exp_up [$];
    logic                     held [2];
    link_mon_pkg::abort_cnt_t exp_abort [2];
    logic                     exp_ovf;
    logic [15:0]              lfsr [2];
    int                       ack_delay;
    int                       err_cnt;
    int                       rpt_cnt;
    int                       cycle_cnt;
    int                       cycle_limit;
    logic                     req_seen;

    link_monitor_top #(.NIBBLES(NIBBLES)) uut (
        .iol2clk(iol2clk), .rst_n(rst_n), .dn_link(dn_link), .up_link(up_link),
        .rpt_ack(rpt_ack), .rpt_req(rpt_req), .rpt(rpt), .overflow(overflow),
        .dn_abort_cnt(dn_abort_cnt), .up_abort_cnt(up_abort_cnt)
    );

    always #4 iol2clk = ~iol2clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Each direction steps its own register, one step per stall bit
    function automatic logic random_bit(input int dir);
        logic b;
        b = lfsr[dir][0];
        lfsr[dir] = lfsr_next(lfsr[dir]);
        return b;
    endfunction

    function automatic link_mon_pkg::nibble_t nibble_at(input link_mon_pkg::packet_t data,
                                                        input int idx);
        link_mon_pkg::nibble_t n;
        n = data[(idx % SLOTS) * link_mon_pkg::NIBBLE_W +: link_mon_pkg::NIBBLE_W];
        // Beats past the packet carry different data so a leak would show
        if (idx >= NIBBLES)
            n = ~n;
        return n;
    endfunction

    function automatic logic known_cmd(input int dir, input logic [3:0] code);
        if (dir == 0)
            return code inside {4'b0100, 4'b0101, 4'b0110};
        return code inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1000, 4'b1100};
    endfunction

    function automatic link_mon_pkg::report_t expected_report(input int dir,
                                                              input link_mon_pkg::packet_t data,
                                                              input int stalls);
        link_mon_pkg::report_t r;
        link_mon_pkg::packet_t mask;
        int                    b;
        mask = '0;
        for (b = 0; b < NIBBLES * link_mon_pkg::NIBBLE_W; b++)
            mask[b] = 1'b1;
        r.dir       = (dir == 0) ? link_mon_pkg::DIR_DOWN : link_mon_pkg::DIR_UP;
        r.cmd       = data[3:0];
        r.cmd_known = known_cmd(dir, data[3:0]);
        r.stall_cnt = (stalls > 255) ? 8'hFF : link_mon_pkg::stall_cnt_t'(stalls);
        r.packet    = data & mask;
        return r;
    endfunction

    function automatic bit pop_expected(input link_mon_pkg::dir_e dir,
                                        output link_mon_pkg::report_t r);
        if (dir == link_mon_pkg::DIR_DOWN && exp_dn.size() > 0)
        begin
            r = exp_dn.pop_front();
            return 1'b1;
        end
        if (dir == link_mon_pkg::DIR_UP && exp_up.size() > 0)
        begin
            r = exp_up.pop_front();
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic report_error(input string msg);
        err_cnt++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic check_report(input link_mon_pkg::report_t got,
                                input link_mon_pkg::report_t want, input string what);
        if (got !== want)
        begin
            err_cnt++;
            $display("Mismatch at %0t: %s, got dir=%0d cmd=%h known=%0d stalls=%0d pkt=%h",
                     $time, what, got.dir, got.cmd, got.cmd_known, got.stall_cnt, got.packet);
            $display("    expected dir=%0d cmd=%h known=%0d stalls=%0d pkt=%h",
                     want.dir, want.cmd, want.cmd_known, want.stall_cnt, want.packet);
        end
    endtask

    task automatic check_abort_cnt(input link_mon_pkg::abort_cnt_t got,
                                   input link_mon_pkg::abort_cnt_t want, input string what);
        if (got !== want)
        begin
            err_cnt++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_overflow(input logic got, input logic want);
        if (got !== want)
        begin
            err_cnt++;
            $display("Mismatch at %0t: overflow is %b, expected %b", $time, got, want);
        end
    endtask

    task automatic drive_link(input int dir, input link_mon_pkg::link_t v);
        if (dir == 0)
            dn_link <= v;
        else
            up_link <= v;
    endtask

    // Sends beats until the count is accepted and counts stall rising edges
    task automatic send_packet(input int dir, input int beats, input bit stall_en,
                               input link_mon_pkg::packet_t data, output int stalls);
        int                  sent;
        logic                stall;
        logic                stall_prev;
        link_mon_pkg::link_t beat;
        sent = 0;
        stalls = 0;
        stall_prev = 1'b0;
        while (sent < beats)
        begin
            @(negedge iol2clk);
            stall = stall_en ? random_bit(dir) : 1'b0;
            if (stall && !stall_prev)
                stalls++;
            beat.vld   = 1'b1;
            beat.data  = nibble_at(data, sent);
            beat.stall = stall;
            drive_link(dir, beat);
            if (!stall)
                sent++;
            stall_prev = stall;
        end
        @(negedge iol2clk);
        beat = '0;
        drive_link(dir, beat);
    endtask

    task automatic run_test(input int idx);
        int                    stalls;
        link_mon_pkg::report_t want;
        send_packet(t_dir[idx], t_beats[idx], t_stall[idx] != 0, t_pkt[idx], stalls);
        if (t_beats[idx] < NIBBLES)
            exp_abort[t_dir[idx]]++;
        else if (held[t_dir[idx]])
            exp_ovf = 1'b1;
        else
        begin
            held[t_dir[idx]] = 1'b1;
            want = expected_report(t_dir[idx], t_pkt[idx], stalls);
            if (t_dir[idx] == 0)
                exp_dn.push_back(want);
            else
                exp_up.push_back(want);
        end
    endtask

    // Idle means nothing expected and the handshake at rest for 8 cycles
    task automatic wait_idle();
        int idle;
        idle = 0;
        while (idle < 8)
        begin
            @(negedge iol2clk);
            if (exp_dn.size() == 0 && exp_up.size() == 0 && !rpt_req && !rpt_ack)
                idle++;
            else
                idle = 0;
        end
    endtask

    task automatic load_tests();
        int                    fd;
        int                    got;
        string                 line;
        int                    d, m, b, s, a;
        link_mon_pkg::packet_t p;
        n_tests = 0;
        cycle_limit = 300;
        fd = $fopen("link_monitor_input.txt", "r");
        if (fd != 0)
        begin
            while (!$feof(fd) && n_tests < MAX_TESTS)
            begin
                line = "";
                got = $fgets(line, fd);
                if (got > 0 && line[0] != "#")
                begin
                    got = $sscanf(line, "%d %d %d %d %d %h", d, m, b, s, a, p);
                    if (got == 6)
                    begin
                        t_dir[n_tests]   = d;
                        t_mode[n_tests]  = m;
                        t_beats[n_tests] = b;
                        t_stall[n_tests] = s;
                        t_delay[n_tests] = a;
                        t_pkt[n_tests]   = p;
                        cycle_limit += b * 3 + a + 64;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_all();
        int i;
        int k;
        int first;
        int errs_before;
        int failed;
        i = 0;
        failed = 0;
        while (i < n_tests)
        begin
            first = i;
            errs_before = err_cnt;
            ack_delay = t_delay[i];
            if (t_mode[i] == 1 && i + 1 < n_tests)
            begin
                fork
                    run_test(first);
                    run_test(first + 1);
                join
                i += 2;
            end
            else
            begin
                run_test(i);
                // Mode 2 chains the next line on without waiting for reports
                while (t_mode[i] == 2 && i + 1 < n_tests)
                begin
                    i++;
                    run_test(i);
                end
                i++;
            end
            wait_idle();
            check_abort_cnt(dn_abort_cnt, exp_abort[0], "downstream abort count");
            check_abort_cnt(up_abort_cnt, exp_abort[1], "upstream abort count");
            check_overflow(overflow, exp_ovf);
            for (k = first; k < i; k++)
            begin
                if (err_cnt != errs_before)
                    failed++;
                $display("Test %0d: %s, %0d beats, %s", k, t_dir[k] ? "upstream" : "downstream",
                         t_beats[k], (err_cnt == errs_before) ? "ok" : "failed");
            end
        end
        $display("Summary: %0d tests, %0d failed, %0d reports, %0d errors",
                 n_tests, failed, rpt_cnt, err_cnt);
    endtask

    always @(posedge iol2clk)
    begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Request may only rise once ack has been seen low
    always @(negedge iol2clk)
    begin
        if (rst_n && rpt_req && !req_seen && rpt_ack)
            report_error("report request rose while ack was still high");
        req_seen = rpt_req;
    end

    always
    begin
        link_mon_pkg::report_t want;
        @(negedge iol2clk);
        if (rst_n && rpt_req && !rpt_ack)
        begin
            repeat (ack_delay) @(negedge iol2clk);
            if (!pop_expected(rpt.dir, want))
                report_error("a report arrived that no test expects");
            else
                check_report(rpt, want, "report record");
            held[rpt.dir] = 1'b0;
            rpt_cnt++;
            rpt_ack <= 1'b1;
            do
                @(negedge iol2clk);
            while (rpt_req);
            // Ack lingers after req falls so a request raised too early shows up
            repeat (2) @(negedge iol2clk);
            rpt_ack <= 1'b0;
        end
    end

    initial
    begin
        iol2clk = 1'b0;
        rst_n = 1'b0;
        dn_link = '0;
        up_link = '0;
        rpt_ack = 1'b0;
        held[0] = 1'b0;
        held[1] = 1'b0;
        exp_abort[0] = '0;
        exp_abort[1] = '0;
        exp_ovf = 1'b0;
        lfsr[0] = 16'd65;
        lfsr[1] = 16'd65;
        ack_delay = 0;
        err_cnt = 0;
        rpt_cnt = 0;
        cycle_cnt = 0;
        req_seen = 1'b0;
        load_tests();
        if (n_tests == 0)
        begin
            $display("Could not read any test from link_monitor_input.txt");
            $display("TEST FAIL");
        end
        else
        begin
            repeat (16) @(negedge iol2clk);
            rst_n <= 1'b1;
            run_all();
            if (err_cnt == 0)
                $display("TEST PASS");
            else
                $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- link_monitor_input.txt
# dir(0 down, 1 up) mode(0 alone, 1 parallel with next, 2 chain next) beats stall_en ack_delay
# packet in hex, first nibble is the lowest digit
# Downstream commands and one unknown code
0 0 32 0 2 0f1e2d3c4b5a69788796a5b4c3d2e1f4
0 0 32 0 0 1122334455667788990aabbccddeeff5
0 0 32 0 5 fedcba98765432100123456789abcde6
0 0 32 0 1 a5a5a5a55a5a5a5a0000ffff1234567f
# Upstream commands and one unknown code
1 0 32 0 1 00000000000000000000000000000010
1 0 32 0 3 deadbeefcafef00d0123456789abcd01
1 0 32 0 0 13579bdf02468ace13579bdf02468ac3
1 0 32 0 2 ffffffffffffffffffffffffffffff07
1 0 32 0 0 8000000000000001800000000000ab08
1 0 32 0 4 0123012301230123456745674567456c
1 0 32 0 0 7777777766666666555555554444444a
# Random stalls
0 0 32 1 3 3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c35
1 0 32 1 1 9abcdef012345678fedcba9876543211
0 0 32 1 0 00112233445566778899aabbccddee06
# Extra beats past the packet
0 0 36 0 2 1234123412341234abcdabcdabcdab04
1 0 40 1 0 5555aaaa5555aaaa5555aaaa5555aa0c
# Aborts
0 0 5 0 0 00000000000000000000000000000004
1 0 31 0 0 11111111111111111111111111111111
0 0 1 1 0 22222222222222222222222222222225
1 0 16 1 0 33333333333333333333333333333338
# Parallel traffic
0 1 32 1 3 6666666677777777888888889999aa04
1 0 32 1 3 bbbbbbbbccccccccddddddddeeeeff01
0 1 32 0 0 0a0b0c0d0e0f0102030405060708a905
1 0 32 0 0 a0b0c0d0e0f010203040506070809a0c
0 1 32 0 1 cafebabecafebabecafebabecafeba06
1 0 20 0 0 44444444444444444444444444444448
# Overflow with a slow ack
0 2 32 0 400 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f004
0 2 32 0 400 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f05
0 0 32 0 400 abababababababababababababababa6

//--- Makefile
# Verilator build and run of the link monitor testbench
VERILATOR ?= verilator
TOP       ?= tb_link_monitor
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q '^TEST PASS$$'

clean:
	rm -rf $(OBJ_DIR)

//--- project.f
link_mon_pkg.sv
nibble_assembler.sv
report_builder.sv
report_ctrl.sv
link_monitor_top.sv
tb_link_monitor.sv
